//--- vec_cfg.svh
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Datapath geometry
`define VEC_NR_LANES 4
`define VEC_NR_VREGS 8
`define VEC_NR_LOOPS 4

// Execute cycles per operation inside a lane
`define VEC_LANE_LAT 3

// AXI4-Lite register map
`define VEC_ADDR_INSN   32'h0000_0000
`define VEC_ADDR_RESULT 32'h0000_0004
`define VEC_ADDR_STATUS 32'h0000_0008

`endif

//--- verilog/vec_pkg.sv
package vec_pkg;

  // Vector opcodes, carried in bits 31:28 of the instruction word
  typedef enum logic [3:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VAND    = 4'd2,
    VXOR    = 4'd3,
    VIDX    = 4'd4,
    VREDSUM = 4'd5,
    VMVXS   = 4'd6,
    VNOP    = 4'd7
  } vec_op_e;

  typedef enum logic {
    IDLE,
    WAIT_RES
  } seq_state_e;

  typedef logic [1:0]  loop_id_t;
  typedef logic [2:0]  vreg_idx_t;
  typedef logic [31:0] elem_t;

  // Ops that return a scalar to the host instead of writing vd
  function automatic logic is_scalar_op(vec_op_e op);
    return op inside {VREDSUM, VMVXS};
  endfunction

endpackage

//--- verilog/vec_axil_frontend.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_axil_frontend import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        s_awvalid_i,
  output logic        s_awready_o,
  input  logic [31:0] s_awaddr_i,
  input  logic        s_wvalid_i,
  output logic        s_wready_o,
  input  logic [31:0] s_wdata_i,
  output logic        s_bvalid_o,
  input  logic        s_bready_i,
  output logic [1:0]  s_bresp_o,
  input  logic        s_arvalid_i,
  output logic        s_arready_o,
  input  logic [31:0] s_araddr_i,
  output logic        s_rvalid_o,
  input  logic        s_rready_i,
  output logic [31:0] s_rdata_o,
  output logic [1:0]  s_rresp_o,
  output logic        insn_valid_o,
  input  logic        insn_ready_i,
  output vec_op_e     insn_op_o,
  output vreg_idx_t   insn_vd_o,
  output vreg_idx_t   insn_vs1_o,
  output vreg_idx_t   insn_vs2_o,
  output logic [15:0] insn_imm_o,
  input  logic        commit_i,
  input  logic        scalar_valid_i,
  input  elem_t       scalar_i,
  input  logic        busy_i
);

  logic  pending_q;
  logic  sent_q;
  logic  wr_hs;
  logic  rd_hs;
  logic  insn_addr;
  elem_t result_q;

  // AW and W are taken together, only with nothing pending
  assign s_awready_o = s_awvalid_i && s_wvalid_i && !pending_q && !s_bvalid_o;
  assign s_wready_o  = s_awready_o;
  assign wr_hs       = s_awready_o;
  assign insn_addr   = s_awaddr_i == `VEC_ADDR_INSN;

  assign insn_valid_o = pending_q && !sent_q;

  assign s_arready_o = !s_rvalid_o;
  assign rd_hs       = s_arvalid_i && s_arready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      sent_q     <= 1'b0;
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
      result_q   <= '0;
    end else begin
      if (s_bvalid_o && s_bready_i) s_bvalid_o <= 1'b0;
      // A bad write address answers at once and issues nothing
      if (wr_hs && insn_addr) pending_q <= 1'b1;
      if (wr_hs && !insn_addr) s_bvalid_o <= 1'b1;
      if (insn_valid_o && insn_ready_i) sent_q <= 1'b1;
      if (commit_i) begin
        pending_q  <= 1'b0;
        sent_q     <= 1'b0;
        s_bvalid_o <= 1'b1;
      end
      if (commit_i && scalar_valid_i) result_q <= scalar_i;
      if (rd_hs) begin
        s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

  // Decoded instruction, response code and read data
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      s_bresp_o <= insn_addr ? 2'b00 : 2'b10;
    end
    if (wr_hs && insn_addr) begin
      insn_op_o  <= vec_op_e'(s_wdata_i[31:28]);
      insn_vd_o  <= s_wdata_i[26:24];
      insn_vs1_o <= s_wdata_i[22:20];
      insn_vs2_o <= s_wdata_i[18:16];
      insn_imm_o <= s_wdata_i[15:0];
    end
    if (rd_hs) begin
      case (s_araddr_i)
        `VEC_ADDR_RESULT: begin
          s_rdata_o <= result_q;
          s_rresp_o <= 2'b00;
        end
        `VEC_ADDR_STATUS: begin
          s_rdata_o <= {30'd0, pending_q, busy_i};
          s_rresp_o <= 2'b00;
        end
        default: begin
          s_rdata_o <= '0;
          s_rresp_o <= 2'b10;
        end
      endcase
    end
  end

  // The sequencer may sample the decode late, so it must not move
  a_insn_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_valid_o && !insn_ready_i |=> insn_valid_o &&
      $stable({insn_op_o, insn_vd_o, insn_vs1_o, insn_vs2_o, insn_imm_o}));

endmodule

//--- verilog/vec_sequencer.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  insn_valid_i,
  output logic                                  insn_ready_o,
  input  vec_op_e                               insn_op_i,
  input  vreg_idx_t                             insn_vd_i,
  input  vreg_idx_t                             insn_vs1_i,
  input  vreg_idx_t                             insn_vs2_i,
  input  logic [15:0]                           insn_imm_i,
  output logic                                  commit_o,
  output logic                                  scalar_valid_o,
  output elem_t                                 scalar_o,
  output logic                                  busy_o,
  input  logic [`VEC_NR_LANES-1:0]              lane_ready_i,
  input  logic [`VEC_NR_LANES-1:0]              lane_done_i,
  input  loop_id_t [`VEC_NR_LANES-1:0]          lane_done_id_i,
  input  logic                                  sum_valid_i,
  input  elem_t                                 sum_i,
  output logic                                  issue_valid_o,
  output vec_op_e                               issue_op_o,
  output loop_id_t                              issue_id_o,
  output vreg_idx_t                             issue_vd_o,
  output vreg_idx_t                             issue_vs1_o,
  output vreg_idx_t                             issue_vs2_o,
  output logic [15:0]                           issue_imm_o,
  output logic [`VEC_NR_LOOPS-1:0]              issue_hzd_o,
  output logic [`VEC_NR_LOOPS-1:0]              loop_running_o
);

  seq_state_e state_q;

  // Running bit per lane and per loop ID
  logic [`VEC_NR_LANES-1:0][`VEC_NR_LOOPS-1:0] lane_run_q;
  logic [`VEC_NR_LOOPS-1:0] loop_running;
  logic                     loops_full;
  loop_id_t                 next_id;

  // Last reader and last writer of every vector register
  logic [`VEC_NR_VREGS-1:0] rd_vld_q;
  logic [`VEC_NR_VREGS-1:0] wr_vld_q;
  logic [`VEC_NR_VREGS-1:0] rd_live;
  logic [`VEC_NR_VREGS-1:0] wr_live;
  loop_id_t                 rd_id_q [`VEC_NR_VREGS];
  loop_id_t                 wr_id_q [`VEC_NR_VREGS];

  logic [`VEC_NR_LOOPS-1:0] hzd;
  logic                     use_vs1;
  logic                     use_vs2;
  logic                     wr_vd;
  logic                     xfer;

  always_comb begin
    loop_running = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      loop_running |= lane_run_q[l];
    end
  end

  assign loop_running_o = loop_running;
  assign loops_full     = &loop_running;
  assign busy_o         = |loop_running || state_q == WAIT_RES;

  // Lowest free loop ID
  always_comb begin
    next_id = '0;
    for (int i = `VEC_NR_LOOPS - 1; i >= 0; i--) begin
      if (!loop_running[i]) next_id = loop_id_t'(i);
    end
  end

  assign insn_ready_o = state_q == IDLE && &lane_ready_i && !loops_full;
  assign xfer         = insn_valid_i && insn_ready_o;

  // List entries die with their loop
  always_comb begin
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      rd_live[r] = rd_vld_q[r] && loop_running[rd_id_q[r]];
      wr_live[r] = wr_vld_q[r] && loop_running[wr_id_q[r]];
    end
  end

  always_comb begin
    use_vs1 = insn_op_i inside {VADD, VSUB, VAND, VXOR, VREDSUM, VMVXS};
    use_vs2 = insn_op_i inside {VADD, VSUB, VAND, VXOR};
    wr_vd   = insn_op_i inside {VADD, VSUB, VAND, VXOR, VIDX};
    hzd     = '0;
    // RAW
    if (use_vs1 && wr_live[insn_vs1_i]) hzd[wr_id_q[insn_vs1_i]] = 1'b1;
    if (use_vs2 && wr_live[insn_vs2_i]) hzd[wr_id_q[insn_vs2_i]] = 1'b1;
    // WAR and WAW
    if (wr_vd && rd_live[insn_vd_i]) hzd[rd_id_q[insn_vd_i]] = 1'b1;
    if (wr_vd && wr_live[insn_vd_i]) hzd[wr_id_q[insn_vd_i]] = 1'b1;
    hzd[next_id] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      lane_run_q     <= '0;
      rd_vld_q       <= '0;
      wr_vld_q       <= '0;
      issue_valid_o  <= 1'b0;
      commit_o       <= 1'b0;
      scalar_valid_o <= 1'b0;
    end else begin
      issue_valid_o  <= xfer;
      commit_o       <= 1'b0;
      scalar_valid_o <= 1'b0;
      rd_vld_q       <= rd_live;
      wr_vld_q       <= wr_live;
      for (int l = 0; l < `VEC_NR_LANES; l++) begin
        if (lane_done_i[l]) lane_run_q[l][lane_done_id_i[l]] <= 1'b0;
      end
      if (xfer) begin
        for (int l = 0; l < `VEC_NR_LANES; l++) begin
          lane_run_q[l][next_id] <= 1'b1;
        end
        if (use_vs1) rd_vld_q[insn_vs1_i] <= 1'b1;
        if (use_vs2) rd_vld_q[insn_vs2_i] <= 1'b1;
        if (wr_vd) wr_vld_q[insn_vd_i] <= 1'b1;
        // Scalar ops hold the host until the lanes report back
        if (is_scalar_op(insn_op_i)) begin
          state_q <= WAIT_RES;
        end else begin
          commit_o <= 1'b1;
        end
      end
      if (state_q == WAIT_RES && sum_valid_i) begin
        state_q        <= IDLE;
        commit_o       <= 1'b1;
        scalar_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      issue_op_o  <= insn_op_i;
      issue_id_o  <= next_id;
      issue_vd_o  <= insn_vd_i;
      issue_vs1_o <= insn_vs1_i;
      issue_vs2_o <= insn_vs2_i;
      issue_imm_o <= insn_imm_i;
      issue_hzd_o <= hzd;
      if (use_vs1) rd_id_q[insn_vs1_i] <= next_id;
      if (use_vs2) rd_id_q[insn_vs2_i] <= next_id;
      if (wr_vd) wr_id_q[insn_vd_i] <= next_id;
    end
    if (sum_valid_i) scalar_o <= sum_i;
  end

  // A new loop always takes an ID that no lane still runs
  a_alloc_free_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    xfer |-> !loop_running[next_id]);

endmodule

//--- verilog/vec_lane.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_lane import vec_pkg::*; #(
  parameter int LANE_IDX = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     issue_valid_i,
  input  vec_op_e                  issue_op_i,
  input  loop_id_t                 issue_id_i,
  input  vreg_idx_t                issue_vd_i,
  input  vreg_idx_t                issue_vs1_i,
  input  vreg_idx_t                issue_vs2_i,
  input  logic [15:0]              issue_imm_i,
  input  logic [`VEC_NR_LOOPS-1:0] issue_hzd_i,
  input  logic [`VEC_NR_LOOPS-1:0] loop_running_i,
  output logic                     ready_o,
  output logic                     done_o,
  output loop_id_t                 done_id_o,
  output logic                     res_valid_o,
  output elem_t                    res_data_o
);

  localparam int LatW = $clog2(`VEC_LANE_LAT + 1);

  // This lane's element of every vector register
  elem_t vrf_q [`VEC_NR_VREGS];

  // Two-entry operation queue
  vec_op_e                  q_op  [2];
  loop_id_t                 q_id  [2];
  vreg_idx_t                q_vd  [2];
  vreg_idx_t                q_vs1 [2];
  vreg_idx_t                q_vs2 [2];
  logic [15:0]              q_imm [2];
  logic [`VEC_NR_LOOPS-1:0] q_hzd [2];
  logic [1:0]               cnt_q;
  logic                     rd_ptr_q;
  logic                     wr_ptr_q;

  logic            busy_q;
  logic [LatW-1:0] lat_q;
  logic            start;
  logic            wr_en;
  vec_op_e         head_op;
  logic [15:0]     head_imm;
  elem_t           op_a;
  elem_t           op_b;
  elem_t           result;

  assign ready_o  = cnt_q != 2'd2;
  assign head_op  = q_op[rd_ptr_q];
  assign head_imm = q_imm[rd_ptr_q];
  assign op_a     = vrf_q[q_vs1[rd_ptr_q]];
  assign op_b     = vrf_q[q_vs2[rd_ptr_q]];

  // Head starts once none of its hazard loops is running
  assign start     = !busy_q && cnt_q != 2'd0 && (q_hzd[rd_ptr_q] & loop_running_i) == '0;
  assign done_o    = busy_q && lat_q == '0;
  assign done_id_o = q_id[rd_ptr_q];

  always_comb begin
    case (head_op)
      VADD:    result = op_a + op_b;
      VSUB:    result = op_a - op_b;
      VAND:    result = op_a & op_b;
      VXOR:    result = op_a ^ op_b;
      VIDX:    result = {{16{head_imm[15]}}, head_imm} + 32'(LANE_IDX);
      VREDSUM: result = op_a;
      // Only the addressed lane contributes its element
      VMVXS:   result = (head_imm == 16'(LANE_IDX)) ? op_a : '0;
      default: result = '0;
    endcase
  end

  assign wr_en       = head_op inside {VADD, VSUB, VAND, VXOR, VIDX};
  assign res_valid_o = done_o && is_scalar_op(head_op);
  assign res_data_o  = result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      busy_q   <= 1'b0;
      lat_q    <= '0;
    end else begin
      cnt_q <= cnt_q + 2'(issue_valid_i) - 2'(done_o);
      if (issue_valid_i) wr_ptr_q <= ~wr_ptr_q;
      if (done_o) begin
        rd_ptr_q <= ~rd_ptr_q;
        busy_q   <= 1'b0;
      end
      if (start) begin
        busy_q <= 1'b1;
        lat_q  <= LatW'(`VEC_LANE_LAT - 1);
      end else if (busy_q && lat_q != '0) begin
        lat_q <= lat_q - LatW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    // Finished loops drop out so a reused ID never stalls an older entry
    for (int i = 0; i < 2; i++) begin
      q_hzd[i] <= q_hzd[i] & loop_running_i;
    end
    if (issue_valid_i) begin
      q_op[wr_ptr_q]  <= issue_op_i;
      q_id[wr_ptr_q]  <= issue_id_i;
      q_vd[wr_ptr_q]  <= issue_vd_i;
      q_vs1[wr_ptr_q] <= issue_vs1_i;
      q_vs2[wr_ptr_q] <= issue_vs2_i;
      q_imm[wr_ptr_q] <= issue_imm_i;
      q_hzd[wr_ptr_q] <= issue_hzd_i & loop_running_i;
    end
    if (done_o && wr_en) vrf_q[q_vd[rd_ptr_q]] <= result;
  end

  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> cnt_q != 2'd2);

endmodule

//--- verilog/vec_result_collect.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_result_collect import vec_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [`VEC_NR_LANES-1:0]        res_valid_i,
  input  elem_t [`VEC_NR_LANES-1:0]       res_data_i,
  output logic                            sum_valid_o,
  output elem_t                           sum_o
);

  logic [`VEC_NR_LANES-1:0] seen_q;
  logic [`VEC_NR_LANES-1:0] seen_d;
  elem_t                    acc_q;
  elem_t                    acc_d;

  // Lanes may finish the same loop in different cycles
  always_comb begin
    acc_d  = acc_q;
    seen_d = seen_q | res_valid_i;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      if (res_valid_i[l]) acc_d = acc_d + res_data_i[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q      <= '0;
      acc_q       <= '0;
      sum_valid_o <= 1'b0;
    end else begin
      sum_valid_o <= &seen_d;
      if (&seen_d) begin
        seen_q <= '0;
        acc_q  <= '0;
      end else begin
        seen_q <= seen_d;
        acc_q  <= acc_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (&seen_d) sum_o <= acc_d;
  end

endmodule

//--- verilog/vec_top.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_top import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        s_awvalid_i,
  output logic        s_awready_o,
  input  logic [31:0] s_awaddr_i,
  input  logic        s_wvalid_i,
  output logic        s_wready_o,
  input  logic [31:0] s_wdata_i,
  output logic        s_bvalid_o,
  input  logic        s_bready_i,
  output logic [1:0]  s_bresp_o,
  input  logic        s_arvalid_i,
  output logic        s_arready_o,
  input  logic [31:0] s_araddr_i,
  output logic        s_rvalid_o,
  input  logic        s_rready_i,
  output logic [31:0] s_rdata_o,
  output logic [1:0]  s_rresp_o
);

  // Frontend to sequencer
  logic        insn_valid;
  logic        insn_ready;
  vec_op_e     insn_op;
  vreg_idx_t   insn_vd;
  vreg_idx_t   insn_vs1;
  vreg_idx_t   insn_vs2;
  logic [15:0] insn_imm;
  logic        commit;
  logic        scalar_valid;
  elem_t       scalar;
  logic        busy;

  // Sequencer broadcast to the lanes
  logic                     issue_valid;
  vec_op_e                  issue_op;
  loop_id_t                 issue_id;
  vreg_idx_t                issue_vd;
  vreg_idx_t                issue_vs1;
  vreg_idx_t                issue_vs2;
  logic [15:0]              issue_imm;
  logic [`VEC_NR_LOOPS-1:0] issue_hzd;
  logic [`VEC_NR_LOOPS-1:0] loop_running;

  // Per-lane returns
  logic [`VEC_NR_LANES-1:0]     lane_ready;
  logic [`VEC_NR_LANES-1:0]     lane_done;
  loop_id_t [`VEC_NR_LANES-1:0] lane_done_id;
  logic [`VEC_NR_LANES-1:0]     res_valid;
  elem_t [`VEC_NR_LANES-1:0]    res_data;
  logic                         sum_valid;
  elem_t                        sum;

  vec_axil_frontend u_frontend (
    .clk_i, .rst_ni,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i,
    .s_bvalid_o, .s_bready_i, .s_bresp_o,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .s_rvalid_o, .s_rready_i, .s_rdata_o, .s_rresp_o,
    .insn_valid_o   (insn_valid),
    .insn_ready_i   (insn_ready),
    .insn_op_o      (insn_op),
    .insn_vd_o      (insn_vd),
    .insn_vs1_o     (insn_vs1),
    .insn_vs2_o     (insn_vs2),
    .insn_imm_o     (insn_imm),
    .commit_i       (commit),
    .scalar_valid_i (scalar_valid),
    .scalar_i       (scalar),
    .busy_i         (busy)
  );

  vec_sequencer u_sequencer (
    .clk_i, .rst_ni,
    .insn_valid_i   (insn_valid),
    .insn_ready_o   (insn_ready),
    .insn_op_i      (insn_op),
    .insn_vd_i      (insn_vd),
    .insn_vs1_i     (insn_vs1),
    .insn_vs2_i     (insn_vs2),
    .insn_imm_i     (insn_imm),
    .commit_o       (commit),
    .scalar_valid_o (scalar_valid),
    .scalar_o       (scalar),
    .busy_o         (busy),
    .lane_ready_i   (lane_ready),
    .lane_done_i    (lane_done),
    .lane_done_id_i (lane_done_id),
    .sum_valid_i    (sum_valid),
    .sum_i          (sum),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_id_o     (issue_id),
    .issue_vd_o     (issue_vd),
    .issue_vs1_o    (issue_vs1),
    .issue_vs2_o    (issue_vs2),
    .issue_imm_o    (issue_imm),
    .issue_hzd_o    (issue_hzd),
    .loop_running_o (loop_running)
  );

  for (genvar i = 0; i < `VEC_NR_LANES; i++) begin : g_lane
    vec_lane #(
      .LANE_IDX(i)
    ) u_lane (
      .clk_i, .rst_ni,
      .issue_valid_i  (issue_valid),
      .issue_op_i     (issue_op),
      .issue_id_i     (issue_id),
      .issue_vd_i     (issue_vd),
      .issue_vs1_i    (issue_vs1),
      .issue_vs2_i    (issue_vs2),
      .issue_imm_i    (issue_imm),
      .issue_hzd_i    (issue_hzd),
      .loop_running_i (loop_running),
      .ready_o        (lane_ready[i]),
      .done_o         (lane_done[i]),
      .done_id_o      (lane_done_id[i]),
      .res_valid_o    (res_valid[i]),
      .res_data_o     (res_data[i])
    );
  end

  vec_result_collect u_collect (
    .clk_i, .rst_ni,
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .sum_valid_o (sum_valid),
    .sum_o       (sum)
  );

endmodule

//--- sim/vec_tb.sv
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_tb import vec_pkg::*; ();

  localparam int HALF_PERIOD = 20;
  // About six tests of under 500 cycles each, with margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        clk;
  logic        rst_n;
  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  int     cycle_cnt = 0;
  int     check_cnt;
  int     error_cnt;
  integer seed;

  // Reference copy of every vector register, one word per element
  logic [31:0] model_vrf [`VEC_NR_VREGS][`VEC_NR_LANES];

  vec_top u_vec_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_awaddr_i  (awaddr),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_wdata_i   (wdata),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_bresp_o   (bresp),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_araddr_i  (araddr),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d mismatches", name, error_cnt - errs_before);
  endtask

  // Inputs change shortly after the rising edge, outputs are read at the falling edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic addr_data_handshake(input logic [31:0] addr, input logic [31:0] data);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic wait_bvalid();
    @(negedge clk);
    while (!bvalid) @(negedge clk);
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    addr_data_handshake(addr, data);
    wait_bvalid();
    resp = bresp;
    next_cycle();
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_cycle();
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  function automatic logic [31:0] encode_insn(input vec_op_e op, input logic [2:0] vd,
                                              input logic [2:0] vs1, input logic [2:0] vs2,
                                              input logic [15:0] imm);
    return {op, 1'b0, vd, 1'b0, vs1, 1'b0, vs2, imm};
  endfunction

  function automatic logic [31:0] expected_scalar(input vec_op_e op, input logic [2:0] vs1,
                                                  input logic [15:0] imm);
    logic [31:0] acc;
    acc = '0;
    if (op == VREDSUM) begin
      for (int i = 0; i < `VEC_NR_LANES; i++) begin
        acc = acc + model_vrf[vs1][i];
      end
    end else if (imm < `VEC_NR_LANES) begin
      acc = model_vrf[vs1][imm[1:0]];
    end
    return acc;
  endfunction

  task automatic model_apply(input vec_op_e op, input logic [2:0] vd, input logic [2:0] vs1,
                             input logic [2:0] vs2, input logic [15:0] imm);
    logic [31:0] a;
    logic [31:0] b;
    int          idx_base;
    idx_base = $signed(imm);
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      a = model_vrf[vs1][i];
      b = model_vrf[vs2][i];
      case (op)
        VADD:    model_vrf[vd][i] = a + b;
        VSUB:    model_vrf[vd][i] = a - b;
        VAND:    model_vrf[vd][i] = a & b;
        VXOR:    model_vrf[vd][i] = a ^ b;
        VIDX:    model_vrf[vd][i] = idx_base + i;
        default: ;
      endcase
    end
  endtask

  // Scalar ops read the result register back and compare it with the model
  task automatic run_insn(input vec_op_e op, input logic [2:0] vd, input logic [2:0] vs1,
                          input logic [2:0] vs2, input logic [15:0] imm);
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] exp;
    exp = expected_scalar(op, vs1, imm);
    axil_write(`VEC_ADDR_INSN, encode_insn(op, vd, vs1, vs2, imm), resp);
    check_val("s_bresp_o", 32'(resp), 32'(RESP_OKAY));
    if (op == VREDSUM || op == VMVXS) begin
      axil_read(`VEC_ADDR_RESULT, data, resp);
      check_val("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
      check_val("s_rdata_o", data, exp);
    end
    model_apply(op, vd, vs1, vs2, imm);
  endtask

  task automatic idle_after_reset();
    int          errs;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = error_cnt;
    check_val("s_bvalid_o", 32'(bvalid), 32'd0);
    check_val("s_rvalid_o", 32'(rvalid), 32'd0);
    check_val("s_awready_o", 32'(awready), 32'd0);
    check_val("s_wready_o", 32'(wready), 32'd0);
    check_val("s_arready_o", 32'(arready), 32'd1);
    axil_read(`VEC_ADDR_STATUS, data, resp);
    check_val("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
    check_val("s_rdata_o", data, 32'd0);
    axil_read(`VEC_ADDR_RESULT, data, resp);
    check_val("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
    check_val("s_rdata_o", data, 32'd0);
    report_test("reset_state", errs);
  endtask

  task automatic index_then_reduce();
    int errs;
    errs = error_cnt;
    run_insn(VIDX, 3'd0, 3'd0, 3'd0, 16'd10);
    run_insn(VREDSUM, 3'd0, 3'd0, 3'd0, 16'd0);
    // Negative start index, sign-extended
    run_insn(VIDX, 3'd7, 3'd0, 3'd0, 16'hFFEC);
    run_insn(VREDSUM, 3'd0, 3'd7, 3'd0, 16'd0);
    report_test("index_reduce", errs);
  endtask

  task automatic hazard_chain();
    int errs;
    errs = error_cnt;
    run_insn(VIDX, 3'd1, 3'd0, 3'd0, 16'd5);
    run_insn(VIDX, 3'd2, 3'd0, 3'd0, 16'hFFFD);
    run_insn(VADD, 3'd3, 3'd1, 3'd2, 16'd0);
    run_insn(VSUB, 3'd1, 3'd3, 3'd2, 16'd0);
    run_insn(VXOR, 3'd2, 3'd1, 3'd3, 16'd0);
    run_insn(VAND, 3'd4, 3'd2, 3'd3, 16'd0);
    for (int r = 1; r <= 4; r++) begin
      run_insn(VREDSUM, 3'd0, 3'(r), 3'd0, 16'd0);
      for (int e = 0; e < `VEC_NR_LANES; e++) begin
        run_insn(VMVXS, 3'd0, 3'(r), 3'd0, 16'(e));
      end
    end
    report_test("hazard_chain", errs);
  endtask

  task automatic random_sequence();
    int          errs;
    logic [31:0] r;
    logic [15:0] imm;
    vec_op_e     op;
    errs = error_cnt;
    // Every register gets known contents first
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      r = $random(seed);
      run_insn(VIDX, 3'(v), 3'd0, 3'd0, r[15:0]);
    end
    for (int n = 0; n < 20; n++) begin
      r   = $random(seed);
      op  = vec_op_e'({1'b0, r[30:28]});
      imm = (op == VMVXS) ? {14'd0, r[1:0]} : r[15:0];
      run_insn(op, r[26:24], r[22:20], r[18:16], imm);
      for (int k = 0; k < 2; k++) begin
        r = $random(seed);
        run_insn(VMVXS, 3'd0, r[6:4], 3'd0, {14'd0, r[1:0]});
      end
    end
    report_test("random_seq", errs);
  endtask

  task automatic write_backpressure();
    int errs;
    errs = error_cnt;
    bready = 1'b0;
    addr_data_handshake(`VEC_ADDR_INSN, encode_insn(VIDX, 3'd5, 3'd0, 3'd0, 16'd100));
    wait_bvalid();
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_val("s_bvalid_o", 32'(bvalid), 32'd1);
    end
    next_cycle();
    // Next write waits behind the stalled response
    awvalid = 1'b1;
    awaddr  = `VEC_ADDR_INSN;
    wvalid  = 1'b1;
    wdata   = encode_insn(VREDSUM, 3'd0, 3'd5, 3'd0, 16'd0);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_val("s_awready_o", 32'(awready), 32'd0);
      check_val("s_wready_o", 32'(wready), 32'd0);
      check_val("s_bvalid_o", 32'(bvalid), 32'd1);
    end
    check_val("s_bresp_o", 32'(bresp), 32'(RESP_OKAY));
    next_cycle();
    bready = 1'b1;
    model_apply(VIDX, 3'd5, 3'd0, 3'd0, 16'd100);
    run_insn(VREDSUM, 3'd0, 3'd5, 3'd0, 16'd0);
    run_insn(VMVXS, 3'd0, 3'd5, 3'd0, 16'd3);
    report_test("backpressure", errs);
  endtask

  task automatic bad_address_errors();
    int          errs;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = error_cnt;
    axil_write(32'h0000_0010, encode_insn(VIDX, 3'd6, 3'd0, 3'd0, 16'd1), resp);
    check_val("s_bresp_o", 32'(resp), 32'(RESP_SLVERR));
    axil_read(32'h0000_000C, data, resp);
    check_val("s_rresp_o", 32'(resp), 32'(RESP_SLVERR));
    check_val("s_rdata_o", data, 32'd0);
    // The rejected write must have left v6 alone
    run_insn(VREDSUM, 3'd0, 3'd6, 3'd0, 16'd0);
    axil_read(`VEC_ADDR_STATUS, data, resp);
    while (data[0]) begin
      axil_read(`VEC_ADDR_STATUS, data, resp);
    end
    check_val("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
    check_val("s_rdata_o", data, 32'd0);
    report_test("error_resp", errs);
  endtask

  initial begin
    seed      = 55846;
    check_cnt = 0;
    error_cnt = 0;
    rst_n     = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b1;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    idle_after_reset();
    index_then_reduce();
    hazard_chain();
    random_sequence();
    write_backpressure();
    bad_address_errors();

    $display("Summary: %0d checks, %0d mismatches", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
verilog/vec_pkg.sv
verilog/vec_axil_frontend.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_result_collect.sv
verilog/vec_top.sv
sim/vec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the vector slice with Verilator and run vec_tb

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f flist.f --top-module vec_tb \
  -Mdir "$BUILD_DIR" -o vec_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/vec_tb_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
